//--- common/armIsaPkg.sv
package armIsaPkg;

  // Condition field, bits 31:28
  typedef enum logic [3:0] {
    EQ = 4'b0000,
    NE,
    CS,
    CC,
    MI,
    PL,
    VS,
    VC,
    HI,
    LS,
    GE,
    LT,
    GT,
    LE,
    AL,
    NV  // Never executes here
  } condT;

  // Data processing opcodes in ARM encoding order
  typedef enum logic [3:0] {
    AND = 4'b0000, EOR, SUB, RSB, ADD, ADC, SBC, RSC,
    TST, TEQ, CMP, CMN, ORR, MOV, BIC, MVN
  } dpOpT;

  typedef enum logic [1:0] {LSL = 2'b00, LSR, ASR, ROR} shiftT;

  localparam logic [3:0] MulTag = 4'b1001;  // Bits 7:4 of a multiply

  typedef struct packed {
    condT        cond;
    logic [1:0]  kind;      // 00 for data processing
    logic        imm;       // Operand2 is a rotated immediate
    dpOpT        op;
    logic        setFlags;
    logic [3:0]  rn;
    logic [3:0]  rd;
    logic [11:0] operand2;  // Rotate/imm8 or shift/rm
  } dpInstrT;

  typedef struct packed {
    condT       cond;
    logic [5:0] zeros;
    logic       accumulate;
    logic       setFlags;
    logic [3:0] rd;         // Destination sits where dp rn is
    logic [3:0] rn;         // Accumulate operand
    logic [3:0] rs;
    logic [3:0] mulTag;
    logic [3:0] rm;
  } mulInstrT;

  // Same word seen as either form
  typedef union packed {
    dpInstrT  dp;
    mulInstrT mul;
  } instrT;

endpackage

//--- common/execPkg.sv
package execPkg;
  import armIsaPkg::*;

  typedef struct packed {
    logic neg;
    logic zero;
    logic carry;
    logic overflow;
  } flagsT;

  // How C and V get updated
  typedef enum logic {
    cvLogic,  // C from shifter, V kept
    cvArith   // C and V from adder
  } cvClassT;

  typedef struct packed {
    condT       cond;
    logic       isMul;
    logic       accumulate;
    dpOpT       aluOp;
    logic       useImm;
    shiftT      shiftType;
    logic [4:0] shiftAmt;
    logic [3:0] rotImm;
    logic [7:0] imm8;
    cvClassT    cvClass;
    logic [1:0] flagsWrite;    // {update NZ, update CV}
    logic       writesResult;
  } ctrlT;

  typedef struct packed {
    logic [31:0] rn;
    logic [31:0] rm;
    logic [31:0] rs;
  } operandsT;

  typedef struct packed {
    logic        valid;
    logic        condEx;
    logic        writesResult;
    logic [31:0] result;
    flagsT       flagsOut;
  } execOutT;

endpackage

//--- run.sh
#!/bin/sh
# Build and run with Verilator, then search the log for the fail line
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -Wno-fatal --top-module executeStageTb \
  -f vlog.f -Mdir obj_dir -o executeStageSim > build.log 2>&1 \
  && ./obj_dir/executeStageSim +verilator+error+limit+1000 > sim.log 2>&1 \
  && ! grep -q "Testbench failed" sim.log \
  && echo "PASS" \
  || { echo "FAIL, see build.log and sim.log"; exit 1; }

//--- src/alu.sv
`timescale 1ns/1ps

module alu
  import armIsaPkg::*, execPkg::*;
(
  input  ctrlT        ctrl,
  input  logic [31:0] rn,
  input  logic [31:0] rs,
  input  logic [31:0] shifterOut,
  input  logic        carryIn,
  output logic [31:0] aluResult,
  output flagsT       aluFlags
);

  logic [31:0] addA;
  logic [31:0] addB;
  logic        addCin;
  logic [32:0] sum;
  logic [31:0] dpResult;
  logic [31:0] mulResult;

  // One adder, subtract forms invert an input and add carry
  always_comb begin
    addA   = rn;
    addB   = shifterOut;
    addCin = 1'b0;
    case (ctrl.aluOp)
      SUB, CMP: begin
        addB   = ~shifterOut;
        addCin = 1'b1;
      end
      RSB: begin
        addA   = shifterOut;
        addB   = ~rn;
        addCin = 1'b1;
      end
      ADC: addCin = carryIn;
      SBC: begin
        addB   = ~shifterOut;
        addCin = carryIn;   // Borrow is not C
      end
      RSC: begin
        addA   = shifterOut;
        addB   = ~rn;
        addCin = carryIn;
      end
      default: ;
    endcase
  end

  assign sum = {1'b0, addA} + {1'b0, addB} + {32'b0, addCin};

  always_comb begin
    case (ctrl.aluOp)
      AND, TST: dpResult = rn & shifterOut;
      EOR, TEQ: dpResult = rn ^ shifterOut;
      ORR:      dpResult = rn | shifterOut;
      MOV:      dpResult = shifterOut;
      BIC:      dpResult = rn & ~shifterOut;
      MVN:      dpResult = ~shifterOut;
      default:  dpResult = sum[31:0];  // Arithmetic and compares
    endcase
  end

  // rm arrives unshifted through the shifter
  assign mulResult = shifterOut * rs + (ctrl.accumulate ? rn : 32'b0);

  assign aluResult = ctrl.isMul ? mulResult : dpResult;

  assign aluFlags.neg      = aluResult[31];
  assign aluFlags.zero     = (aluResult == 32'b0);
  assign aluFlags.carry    = sum[32];  // No-borrow for subtracts
  // Same input signs but result sign differs
  assign aluFlags.overflow = (addA[31] == addB[31]) && (sum[31] != addA[31]);

endmodule

//--- src/barrelShifter.sv
`timescale 1ns/1ps

module barrelShifter
  import armIsaPkg::*;
(
  input  logic [31:0] value,
  input  logic [7:0]  imm8,
  input  logic        useImm,
  input  logic [3:0]  rotImm,
  input  shiftT       shiftType,
  input  logic [4:0]  shiftAmt,
  input  logic        carryIn,
  output logic [31:0] shifterOut,
  output logic        shifterCarry
);

  logic [31:0] immExt;
  logic [4:0]  rotAmt;
  logic [31:0] immRot;
  logic [32:0] lslWide;  // {carry, result}
  logic [32:0] lsrWide;  // {result, carry}
  logic [32:0] asrWide;  // {result, carry}
  logic [31:0] rorVal;

  // Immediate rotated right by twice rotImm
  assign immExt = {24'b0, imm8};
  assign rotAmt = {rotImm, 1'b0};
  assign immRot = (immExt >> rotAmt) | (immExt << (6'd32 - {1'b0, rotAmt}));

  // Extra bit catches the last bit shifted out
  assign lslWide = {1'b0, value} << shiftAmt;
  assign lsrWide = {value, 1'b0} >> shiftAmt;
  assign asrWide = $signed({value, 1'b0}) >>> shiftAmt;
  assign rorVal  = (value >> shiftAmt) | (value << (6'd32 - {1'b0, shiftAmt}));

  always_comb begin
    shifterOut   = value;
    shifterCarry = carryIn;  // Zero shift keeps C
    if (useImm) begin
      shifterOut = immRot;
      if (rotImm != 4'd0) shifterCarry = immRot[31];
    end else begin
      case (shiftType)
        LSL: if (shiftAmt != 5'd0) {shifterCarry, shifterOut} = lslWide;
        LSR: if (shiftAmt == 5'd0) begin  // LSR #32
          shifterOut   = '0;
          shifterCarry = value[31];
        end else begin
          {shifterOut, shifterCarry} = lsrWide;
        end
        ASR: if (shiftAmt == 5'd0) begin  // ASR #32
          shifterOut   = {32{value[31]}};
          shifterCarry = value[31];
        end else begin
          {shifterOut, shifterCarry} = asrWide;
        end
        ROR: if (shiftAmt == 5'd0) begin  // RRX
          shifterOut   = {carryIn, value[31:1]};
          shifterCarry = value[0];
        end else begin
          shifterOut   = rorVal;
          shifterCarry = rorVal[31];
        end
      endcase
    end
  end

endmodule

//--- src/conditional.sv
`timescale 1ns/1ps

module conditional
  import armIsaPkg::*, execPkg::*;
(
  input  condT       cond,
  input  flagsT      flags,         // Stored flags
  input  flagsT      aluFlags,
  input  logic       shifterCarry,
  input  logic [1:0] flagsWrite,    // {update NZ, update CV}
  input  cvClassT    cvClass,
  output logic       condEx,
  output flagsT      flagsNext,
  output flagsT      flagsOut       // Candidate flags before write gating
);

  logic ge;
  logic nzUpdate;
  logic cvUpdate;

  assign ge = (flags.neg == flags.overflow);

  always_comb begin
    case (cond)
      EQ:      condEx = flags.zero;
      NE:      condEx = ~flags.zero;
      CS:      condEx = flags.carry;
      CC:      condEx = ~flags.carry;
      MI:      condEx = flags.neg;
      PL:      condEx = ~flags.neg;
      VS:      condEx = flags.overflow;
      VC:      condEx = ~flags.overflow;
      HI:      condEx = flags.carry & ~flags.zero;
      LS:      condEx = ~(flags.carry & ~flags.zero);
      GE:      condEx = ge;
      LT:      condEx = ~ge;
      GT:      condEx = ~flags.zero & ge;
      LE:      condEx = ~(~flags.zero & ge);
      AL:      condEx = 1'b1;
      default: condEx = 1'b0;  // NV
    endcase
  end

  // NZ straight from result
  assign flagsOut.neg  = aluFlags.neg;
  assign flagsOut.zero = aluFlags.zero;

  // Logic ops take shifter carry and hold V
  assign flagsOut.carry    = (cvClass == cvLogic) ? shifterCarry : aluFlags.carry;
  assign flagsOut.overflow = (cvClass == cvLogic) ? flags.overflow : aluFlags.overflow;

  assign nzUpdate = flagsWrite[1] & condEx;
  assign cvUpdate = flagsWrite[0] & condEx;

  assign flagsNext.neg      = nzUpdate ? flagsOut.neg      : flags.neg;
  assign flagsNext.zero     = nzUpdate ? flagsOut.zero     : flags.zero;
  assign flagsNext.carry    = cvUpdate ? flagsOut.carry    : flags.carry;
  assign flagsNext.overflow = cvUpdate ? flagsOut.overflow : flags.overflow;

endmodule

//--- src/executeStage.sv
`timescale 1ns/1ps

module executeStage
  import armIsaPkg::*, execPkg::*;
(
  input  logic     clk,
  input  logic     rst,
  input  logic     instrValid,
  input  instrT    instr,
  input  operandsT operands,
  output execOutT  out,
  output flagsT    flags      // NZCV register
);

  ctrlT        ctrl;
  logic [31:0] shifterOut;
  logic        shifterCarry;
  logic [31:0] aluResult;
  flagsT       aluFlags;
  logic        condEx;
  flagsT       flagsNext;
  flagsT       flagsOut;
  logic        validQ;
  logic        condExQ;
  logic        writesResultQ;
  logic [31:0] resultQ;
  flagsT       flagsOutQ;

  instrDecoder u_instrDecoder (
    .instr (instr),
    .ctrl  (ctrl)
  );

  barrelShifter u_barrelShifter (
    .value        (operands.rm),
    .imm8         (ctrl.imm8),
    .useImm       (ctrl.useImm),
    .rotImm       (ctrl.rotImm),
    .shiftType    (ctrl.shiftType),
    .shiftAmt     (ctrl.shiftAmt),
    .carryIn      (flags.carry),    // Needed for RRX and zero shifts
    .shifterOut   (shifterOut),
    .shifterCarry (shifterCarry)
  );

  alu u_alu (
    .ctrl       (ctrl),
    .rn         (operands.rn),
    .rs         (operands.rs),
    .shifterOut (shifterOut),
    .carryIn    (flags.carry),
    .aluResult  (aluResult),
    .aluFlags   (aluFlags)
  );

  conditional u_conditional (
    .cond         (ctrl.cond),
    .flags        (flags),
    .aluFlags     (aluFlags),
    .shifterCarry (shifterCarry),
    .flagsWrite   (ctrl.flagsWrite),
    .cvClass      (ctrl.cvClass),
    .condEx       (condEx),
    .flagsNext    (flagsNext),
    .flagsOut     (flagsOut)
  );

  // flagsNext already holds old flags when nothing writes
  always_ff @(posedge clk) begin
    if (rst) begin
      flags   <= '0;
      validQ  <= 1'b0;
      condExQ <= 1'b0;
    end else begin
      validQ  <= instrValid;
      condExQ <= instrValid & condEx;  // Low on idle cycles
      if (instrValid) flags <= flagsNext;
    end
  end

  always_ff @(posedge clk) begin
    if (instrValid) begin
      writesResultQ <= ctrl.writesResult;
      resultQ       <= aluResult;
      flagsOutQ     <= flagsOut;
    end
  end

  assign out = '{valid: validQ, condEx: condExQ, writesResult: writesResultQ,
                 result: resultQ, flagsOut: flagsOutQ};

endmodule

//--- src/instrDecoder.sv
`timescale 1ns/1ps

module instrDecoder
  import armIsaPkg::*, execPkg::*;
(
  input  instrT instr,
  output ctrlT  ctrl
);

  logic isMul;
  logic isCompare;
  logic isLogic;
  dpOpT op;

  // Multiply has zeros in 27:22 and 1001 in 7:4
  assign isMul = (instr.mul.zeros == 6'b0) && (instr.mul.mulTag == MulTag);
  assign op    = instr.dp.op;

  always_comb begin
    isCompare = 1'b0;
    isLogic   = 1'b0;
    case (op)
      TST, TEQ: begin
        isCompare = 1'b1;
        isLogic   = 1'b1;
      end
      CMP, CMN: isCompare = 1'b1;
      AND, EOR, ORR, MOV, BIC, MVN: isLogic = 1'b1;
      default: ;
    endcase
  end

  always_comb begin
    ctrl      = '0;               // Mul leaves shifter at LSL #0 so rm passes through
    ctrl.cond = instr.dp.cond;    // Same bits in both forms
    if (isMul) begin
      ctrl.isMul        = 1'b1;
      ctrl.accumulate   = instr.mul.accumulate;
      ctrl.cvClass      = cvArith;
      ctrl.flagsWrite   = {instr.mul.setFlags, 1'b0};  // C and V untouched
      ctrl.writesResult = 1'b1;
    end else begin
      ctrl.aluOp        = op;
      ctrl.useImm       = instr.dp.imm;
      ctrl.rotImm       = instr.dp.operand2[11:8];
      ctrl.imm8         = instr.dp.operand2[7:0];
      ctrl.shiftAmt     = instr.dp.operand2[11:7];
      ctrl.shiftType    = shiftT'(instr.dp.operand2[6:5]);
      ctrl.cvClass      = isLogic ? cvLogic : cvArith;
      ctrl.flagsWrite   = {2{isCompare | instr.dp.setFlags}};  // Compares always set
      ctrl.writesResult = ~isCompare;
    end
  end

endmodule

//--- tests/clockGen.sv
`timescale 1ns/1ps

module clockGen (
  output logic clk,
  output logic rst
);

  initial clk = 1'b0;
  always #4 clk = ~clk;  // 8 ns period

  // Reset held for 5 rising edges
  initial begin
    rst = 1'b1;
    repeat (5) @(posedge clk);
    rst <= 1'b0;
  end

endmodule

//--- tests/executeStageTb.sv
`timescale 1ns/1ps

module executeStageTb
  import armIsaPkg::*, execPkg::*;
();

  localparam int TotalInstrs   = 12 * 17 + 64 + 1 + 64 + 32 + 128;
  localparam int TimeoutCycles = TotalInstrs + 100;  // Reset, idle gaps, margin

  localparam logic [31:0] CmpRn [4] = '{32'd0, 32'd1, 32'h7fffffff, 32'h80000000};
  localparam logic [31:0] CmpRm [4] = '{32'd1, 32'd0, 32'hffffffff, 32'd1};
  localparam logic [31:0] MulRm [3] = '{32'd1, 32'd0, 32'hffffffff};  // NZ 00, 01, 10
  localparam dpOpT ArithOps [8] = '{ADD, ADC, SUB, SBC, RSB, RSC, CMP, CMN};
  localparam dpOpT LogicOps [8] = '{AND, EOR, TST, TEQ, ORR, MOV, BIC, MVN};

  logic        clk;
  logic        rst;
  logic        instrValid;
  instrT       instr;
  operandsT    operands;
  execOutT     out;
  flagsT       flags;
  logic [31:0] seed = 32'd65;
  int          issued = 0;
  int          testCount = 0;
  int          errsBefore = 0;

  clockGen u_clockGen (
    .clk (clk),
    .rst (rst)
  );

  executeStage i_executeStage (
    .clk        (clk),
    .rst        (rst),
    .instrValid (instrValid),
    .instr      (instr),
    .operands   (operands),
    .out        (out),
    .flags      (flags)
  );

  bind executeStage executeStage_asserts u_asserts (
    .clk        (clk),
    .rst        (rst),
    .instrValid (instrValid),
    .instr      (instr),
    .operands   (operands),
    .out        (out),
    .flags      (flags)
  );

  function automatic logic [31:0] nextRandom();
    seed = seed * 32'd1103515245 + 32'd12345;
    return {seed[15:0], seed[31:16]};  // High bits move the most
  endfunction

  function automatic instrT dpWord(condT c, dpOpT op, logic s, logic imm, logic [11:0] op2);
    instrT w;
    w.dp = '{cond: c, kind: 2'b00, imm: imm, op: op, setFlags: s, rn: 4'd1, rd: 4'd2,
             operand2: op2};
    return w;
  endfunction

  function automatic instrT mulWord(condT c, logic acc, logic s);
    instrT w;
    w.mul = '{cond: c, zeros: 6'd0, accumulate: acc, setFlags: s, rd: 4'd3, rn: 4'd1,
              rs: 4'd4, mulTag: MulTag, rm: 4'd5};
    return w;
  endfunction

  // Called just after a rising edge
  task automatic issue(instrT w, logic [31:0] rn, logic [31:0] rm, logic [31:0] rs);
    instrValid <= 1'b1;
    instr      <= w;
    operands   <= '{rn: rn, rm: rm, rs: rs};
    issued++;
    @(posedge clk);
  endtask

  task automatic idle(int n);
    instrValid <= 1'b0;
    repeat (n) @(posedge clk);
  endtask

  task automatic finishTest(string name);
    int errs;
    idle(2);  // Let the last result get checked
    errs = i_executeStage.u_asserts.errCount;
    testCount++;
    $display("%-11s done, %0d errors", name, errs - errsBefore);
    errsBefore = errs;
  endtask

  initial begin
    #(TimeoutCycles * 8);
    $display("Timeout, run did not end within %0d cycles", TimeoutCycles);
    $display("Testbench failed");
    $finish;
  end

  initial begin
    logic [31:0] r;
    logic [31:0] a;
    logic [11:0] op2;
    dpOpT        op;
    instrValid = 1'b0;
    instr      = '0;
    operands   = '0;
    @(negedge rst);
    @(posedge clk);
    idle(4);  // Valid low and flags zero meanwhile
    finishTest("reset");

    // C and V from CMP, then N and Z from MULS; N and Z never come up together
    for (int cv = 0; cv < 4; cv++) begin
      for (int nz = 0; nz < 3; nz++) begin
        issue(dpWord(AL, CMP, 1'b1, 1'b0, 12'd0), CmpRn[cv], CmpRm[cv], 32'd0);
        issue(mulWord(AL, 1'b0, 1'b1), 32'd0, MulRm[nz], 32'd1);
        for (int c = 0; c < 15; c++) begin
          issue(dpWord(condT'(c[3:0]), ADD, 1'b0, 1'b0, 12'd0), nextRandom(), nextRandom(),
                32'd0);
        end
      end
    end
    finishTest("conditions");

    for (int n = 0; n < 64; n++) begin
      r  = nextRandom();
      a  = nextRandom();
      op = ArithOps[r[2:0]];
      if (n % 4 == 2) op = ADC;  // ADC then SBC right after a flag update
      if (n % 4 == 3) op = SBC;
      // Bit 4 clear keeps the shift amount an immediate
      issue(dpWord(AL, op, (n % 4 != 0) | r[3], 1'b0, {r[15:9], 1'b0, r[7:4]}), a,
            r[16] ? a : nextRandom(), 32'd0);
    end
    finishTest("arithmetic");

    issue(dpWord(AL, CMP, 1'b1, 1'b0, 12'd0), 32'h7fffffff, 32'hffffffff, 32'd0);  // V set
    for (int n = 0; n < 64; n++) begin
      r = nextRandom();
      if (r[3]) begin
        op2 = r[15:4];  // Rotated imm8
      end else begin
        op2 = {(r[17:16] == 2'b00) ? 5'd0 : r[15:11], r[10:9], 5'd0};  // Often amount 0
      end
      issue(dpWord(AL, LogicOps[r[2:0]], 1'b1, r[3], op2), nextRandom(), nextRandom(),
            32'd0);
    end
    finishTest("logic");

    for (int n = 0; n < 32; n++) begin
      r = nextRandom();
      issue(mulWord(AL, r[0], r[1]), nextRandom(), r[2] ? 32'd0 : nextRandom(),
            nextRandom());
    end
    finishTest("multiply");

    // Any condition but NV, some failing with S set
    for (int n = 0; n < 128; n++) begin
      r = nextRandom();
      if (r[20:18] == 3'b000) begin
        issue(mulWord(condT'(r[31:28] % 4'd15), r[0], r[1]), nextRandom(), nextRandom(),
              nextRandom());
      end else begin
        // Bit 4 only set inside an immediate
        issue(dpWord(condT'(r[31:28] % 4'd15), dpOpT'(r[3:0]), r[4], r[5],
                     {r[17:11], r[10] & r[5], r[9:6]}),
              nextRandom(), nextRandom(), 32'd0);
      end
    end
    finishTest("mixed");

    $display("Tests %0d, instructions %0d, checked %0d, errors %0d", testCount, issued,
             i_executeStage.u_asserts.checkCount, i_executeStage.u_asserts.errCount);
    if (i_executeStage.u_asserts.checkCount != issued) begin
      $display("Checker saw %0d results but %0d instructions were issued",
               i_executeStage.u_asserts.checkCount, issued);
    end
    if (i_executeStage.u_asserts.errCount == 0 &&
        i_executeStage.u_asserts.checkCount == issued) begin
      $display("Testbench passed");
    end else begin
      $display("Testbench failed");
    end
    $finish;
  end

endmodule

//--- tests/executeStage_asserts.sv
`timescale 1ns/1ps

module executeStage_asserts
  import armIsaPkg::*, execPkg::*;
(
  input logic     clk,
  input logic     rst,
  input logic     instrValid,
  input instrT    instr,
  input operandsT operands,
  input execOutT  out,
  input flagsT    flags
);

  int          errCount = 0;
  int          checkCount = 0;
  flagsT       refFlags;     // Model of the NZCV register
  logic        nowMul;
  logic        nowEx;
  logic        nowWr;
  logic [31:0] nowRes;
  flagsT       nowFo;
  flagsT       nowFn;
  logic        expValid;
  logic        expMul;
  logic        expCondEx;
  logic        expWrites;
  logic [31:0] expResult;
  flagsT       expFlagsOut;

  // ARM truth table
  function automatic logic condHolds(condT c, flagsT f);
    case (c)
      EQ: return f.zero;
      NE: return !f.zero;
      CS: return f.carry;
      CC: return !f.carry;
      MI: return f.neg;
      PL: return !f.neg;
      VS: return f.overflow;
      VC: return !f.overflow;
      HI: return f.carry && !f.zero;
      LS: return !f.carry || f.zero;
      GE: return f.neg == f.overflow;
      LT: return f.neg != f.overflow;
      GT: return !f.zero && (f.neg == f.overflow);
      LE: return f.zero || (f.neg != f.overflow);
      AL: return 1'b1;
      default: return 1'b0;
    endcase
  endfunction

  // Returns {carry, operand}
  function automatic logic [32:0] shiftOperand(dpInstrT d, logic [31:0] rm, logic cIn);
    logic [63:0] twice;
    int          n;
    if (d.imm) begin
      n     = 2 * d.operand2[11:8];
      twice = {2{{24'b0, d.operand2[7:0]}}} >> n;  // Low half is the rotated value
      return {(n == 0) ? cIn : twice[31], twice[31:0]};
    end
    n = d.operand2[11:7];
    case (shiftT'(d.operand2[6:5]))
      LSL: if (n == 0) return {cIn, rm};
           else return {rm[32 - n], rm << n};
      LSR: if (n == 0) return {rm[31], 32'd0};  // Shift by 32
           else return {rm[n - 1], rm >> n};
      ASR: if (n == 0) return {rm[31], {32{rm[31]}}};
           else return {rm[n - 1], $signed(rm) >>> n};
      default: begin
        if (n == 0) return {rm[0], cIn, rm[31:1]};  // RRX
        twice = {rm, rm} >> n;
        return {twice[31], twice[31:0]};
      end
    endcase
  endfunction

  function automatic void refExec(input instrT i, input operandsT ops, input flagsT f,
                                  input logic isMul, output logic ex,
                                  output logic [31:0] res, output flagsT fOut,
                                  output flagsT fNext, output logic wr);
    logic [32:0] sh;
    logic [31:0] x;
    logic [31:0] y;
    longint      k;
    longint      wide;
    longint      sres;
    logic        isCmp;
    logic        wrNz;
    logic        wrCv;
    dpOpT        op;
    op    = i.dp.op;
    ex    = condHolds(i.dp.cond, f);
    fOut  = f;
    isCmp = op inside {TST, TEQ, CMP, CMN};
    if (isMul) begin
      res  = ops.rm * ops.rs + (i.mul.accumulate ? ops.rn : 32'd0);
      wr   = 1'b1;
      wrNz = i.mul.setFlags;
      wrCv = 1'b0;  // C and V survive a multiply
    end else begin
      sh   = shiftOperand(i.dp, ops.rm, f.carry);
      wr   = !isCmp;
      wrNz = isCmp || i.dp.setFlags;
      wrCv = wrNz;
      case (op)
        AND, TST: res = ops.rn & sh[31:0];
        EOR, TEQ: res = ops.rn ^ sh[31:0];
        ORR:      res = ops.rn | sh[31:0];
        MOV:      res = sh[31:0];
        BIC:      res = ops.rn & ~sh[31:0];
        MVN:      res = ~sh[31:0];
        default: begin
          // Reverse forms swap the operands
          x = (op inside {RSB, RSC}) ? sh[31:0] : ops.rn;
          y = (op inside {RSB, RSC}) ? ops.rn : sh[31:0];
          k = 0;
          if (op == ADC) k = f.carry;
          if (op inside {SBC, RSC}) k = !f.carry;  // Borrow
          if (op inside {ADD, ADC, CMN}) begin
            wide       = longint'(x) + longint'(y) + k;
            sres       = longint'($signed(x)) + longint'($signed(y)) + k;
            fOut.carry = wide[32];
          end else begin
            wide       = longint'(x) - longint'(y) - k;
            sres       = longint'($signed(x)) - longint'($signed(y)) - k;
            fOut.carry = (wide >= 0);  // No borrow
          end
          res           = wide[31:0];
          fOut.overflow = (sres > 64'sd2147483647) || (sres < -64'sd2147483648);
        end
      endcase
      if (op inside {AND, EOR, TST, TEQ, ORR, MOV, BIC, MVN}) fOut.carry = sh[32];
    end
    fOut.neg  = res[31];
    fOut.zero = (res == 32'd0);
    fNext     = f;
    if (ex && wrNz) {fNext.neg, fNext.zero} = {fOut.neg, fOut.zero};
    if (ex && wrCv) {fNext.carry, fNext.overflow} = {fOut.carry, fOut.overflow};
  endfunction

  always_comb begin
    nowMul = (instr.mul.zeros == 6'd0) && (instr.mul.mulTag == MulTag);
    refExec(instr, operands, refFlags, nowMul, nowEx, nowRes, nowFo, nowFn, nowWr);
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      refFlags <= '0;
      expValid <= 1'b0;
    end else begin
      expValid <= instrValid;
      if (expValid) checkCount <= checkCount + 1;
      if (instrValid) begin
        refFlags    <= nowFn;
        expMul      <= nowMul;
        expCondEx   <= nowEx;
        expWrites   <= nowWr;
        expResult   <= nowRes;
        expFlagsOut <= nowFo;
      end
    end
  end

  validOk: assert property (@(posedge clk) disable iff (rst) out.valid == expValid)
    else begin
      errCount++;
      $error("MISMATCH t=%0t out.valid exp=%0b got=%0b", $time, expValid, out.valid);
    end

  flagsOk: assert property (@(posedge clk) disable iff (rst) flags == refFlags)
    else begin
      errCount++;
      $error("MISMATCH t=%0t flags exp=%4b got=%4b", $time, refFlags, flags);
    end

  condOk: assert property (@(posedge clk) disable iff (rst)
                           expValid |-> out.condEx == expCondEx)
    else begin
      errCount++;
      $error("MISMATCH t=%0t out.condEx exp=%0b got=%0b", $time, expCondEx, out.condEx);
    end

  resultOk: assert property (@(posedge clk) disable iff (rst)
                             expValid |-> out.result == expResult)
    else begin
      errCount++;
      $error("MISMATCH t=%0t out.result exp=%h got=%h", $time, expResult, out.result);
    end

  writesOk: assert property (@(posedge clk) disable iff (rst)
                             expValid |-> out.writesResult == expWrites)
    else begin
      errCount++;
      $error("MISMATCH t=%0t out.writesResult exp=%0b got=%0b", $time, expWrites,
             out.writesResult);
    end

  // Multiply C and V candidates are don't care
  flagsOutOk: assert property (@(posedge clk) disable iff (rst)
                               expValid |-> out.flagsOut[3:2] == expFlagsOut[3:2] &&
                                 (expMul || out.flagsOut[1:0] == expFlagsOut[1:0]))
    else begin
      errCount++;
      $error("MISMATCH t=%0t out.flagsOut exp=%4b got=%4b", $time, expFlagsOut,
             out.flagsOut);
    end

endmodule

//--- vlog.f
common/armIsaPkg.sv
common/execPkg.sv
src/instrDecoder.sv
src/barrelShifter.sv
src/alu.sv
src/conditional.sv
src/executeStage.sv
tests/clockGen.sv
tests/executeStage_asserts.sv
tests/executeStageTb.sv
